//--- cluster.sv
`timescale 1ns/100ps
`default_nettype none

module cluster (
    input  wire                                  clk,
    input  wire                                  reset,

    // Device configuration
    input  wire                                  dcr_wr_valid,
    input  wire  [dcr_pkg::DCR_ADDR_WIDTH-1:0]   dcr_wr_addr,
    input  wire  [dcr_pkg::DCR_DATA_WIDTH-1:0]   dcr_wr_data,
    input  wire                                  start,

    // Memory
    output logic                                 mem_req_valid,
    output logic                                 mem_req_rw,
    output logic [cluster_pkg::ADDR_WIDTH-1:0]   mem_req_addr,
    output logic [cluster_pkg::DATA_WIDTH-1:0]   mem_req_data,
    output logic [cluster_pkg::CORE_ID_WIDTH-1:0] mem_req_tag,
    input  wire                                  mem_req_ready,
    input  wire                                  mem_rsp_valid,
    input  wire  [cluster_pkg::DATA_WIDTH-1:0]   mem_rsp_data,
    input  wire  [cluster_pkg::CORE_ID_WIDTH-1:0] mem_rsp_tag,

    // Status
    output logic                                 busy
);
    import cluster_pkg::*;

    logic [ADDR_WIDTH-1:0]  src_base;
    logic [ADDR_WIDTH-1:0]  dst_base;
    logic [COUNT_WIDTH-1:0] count;
    logic [DATA_WIDTH-1:0]  scale;
    logic [DATA_WIDTH-1:0]  bias;

    logic [NUM_CORES-1:0]                 core_mem_req_valid;
    logic [NUM_CORES-1:0]                 core_mem_req_rw;
    logic [NUM_CORES-1:0][ADDR_WIDTH-1:0] core_mem_req_addr;
    logic [NUM_CORES-1:0][DATA_WIDTH-1:0] core_mem_req_data;
    logic [NUM_CORES-1:0]                 core_mem_req_ready;
    logic [NUM_CORES-1:0]                 core_mem_rsp_valid;
    logic [DATA_WIDTH-1:0]                core_mem_rsp_data;

    logic [NUM_CORES-1:0]                 mul_req_valid;
    logic [NUM_CORES-1:0][DATA_WIDTH-1:0] mul_req_data;
    logic [NUM_CORES-1:0]                 mul_req_ready;
    logic [NUM_CORES-1:0]                 mul_rsp_valid;
    logic [DATA_WIDTH-1:0]                mul_rsp_data;

    logic [NUM_CORES-1:0]                 core_busy;

    dcr_base dcr_base_inst (
        .clk          (clk),
        .reset        (reset),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .src_base     (src_base),
        .dst_base     (dst_base),
        .count        (count),
        .scale        (scale),
        .bias         (bias)
    );

    for (genvar i = 0; i < NUM_CORES; ++i) begin : g_cores
        core #(
            .CORE_ID (i)
        ) core_inst (
            .clk           (clk),
            .reset         (reset),
            .start         (start),
            .src_base      (src_base),
            .dst_base      (dst_base),
            .count         (count),
            .mem_req_valid (core_mem_req_valid[i]),
            .mem_req_rw    (core_mem_req_rw[i]),
            .mem_req_addr  (core_mem_req_addr[i]),
            .mem_req_data  (core_mem_req_data[i]),
            .mem_req_ready (core_mem_req_ready[i]),
            .mem_rsp_valid (core_mem_rsp_valid[i]),
            .mem_rsp_data  (core_mem_rsp_data),
            .mul_req_valid (mul_req_valid[i]),
            .mul_req_data  (mul_req_data[i]),
            .mul_req_ready (mul_req_ready[i]),
            .mul_rsp_valid (mul_rsp_valid[i]),
            .mul_rsp_data  (mul_rsp_data),
            .busy          (core_busy[i])
        );
    end

    mul_unit mul_unit_inst (
        .clk           (clk),
        .reset         (reset),
        .mul_req_valid (mul_req_valid),
        .mul_req_data  (mul_req_data),
        .mul_req_ready (mul_req_ready),
        .scale         (scale),
        .bias          (bias),
        .mul_rsp_valid (mul_rsp_valid),
        .mul_rsp_data  (mul_rsp_data)
    );

    mem_arb mem_arb_inst (
        .clk                (clk),
        .reset              (reset),
        .core_mem_req_valid (core_mem_req_valid),
        .core_mem_req_rw    (core_mem_req_rw),
        .core_mem_req_addr  (core_mem_req_addr),
        .core_mem_req_data  (core_mem_req_data),
        .core_mem_req_ready (core_mem_req_ready),
        .core_mem_rsp_valid (core_mem_rsp_valid),
        .core_mem_rsp_data  (core_mem_rsp_data),
        .mem_req_valid      (mem_req_valid),
        .mem_req_rw         (mem_req_rw),
        .mem_req_addr       (mem_req_addr),
        .mem_req_data       (mem_req_data),
        .mem_req_tag        (mem_req_tag),
        .mem_req_ready      (mem_req_ready),
        .mem_rsp_valid      (mem_rsp_valid),
        .mem_rsp_data       (mem_rsp_data),
        .mem_rsp_tag        (mem_rsp_tag)
    );

    assign busy = |core_busy;

endmodule

`default_nettype wire

//--- cluster_pkg.sv
`default_nettype none

package cluster_pkg;

    // Cluster sizing
    localparam int NUM_CORES     = 2;
    localparam int CORE_ID_WIDTH = 1;

    // Datapath widths
    localparam int ADDR_WIDTH    = 16;
    localparam int DATA_WIDTH    = 32;
    localparam int COUNT_WIDTH   = 8;

    // Core sequencer states
    localparam int STATE_WIDTH = 3;
    localparam logic [STATE_WIDTH-1:0] ST_IDLE      = 3'd0;
    localparam logic [STATE_WIDTH-1:0] ST_READ      = 3'd1;
    localparam logic [STATE_WIDTH-1:0] ST_WAIT_READ = 3'd2;
    localparam logic [STATE_WIDTH-1:0] ST_MUL       = 3'd3;
    localparam logic [STATE_WIDTH-1:0] ST_WAIT_MUL  = 3'd4;
    localparam logic [STATE_WIDTH-1:0] ST_WRITE     = 3'd5;

endpackage

`default_nettype wire

//--- core.sv
`timescale 1ns/100ps
`default_nettype none

module core #(
    parameter int CORE_ID = 0
) (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  start,

    // Launch configuration
    input  wire  [cluster_pkg::ADDR_WIDTH-1:0]   src_base,
    input  wire  [cluster_pkg::ADDR_WIDTH-1:0]   dst_base,
    input  wire  [cluster_pkg::COUNT_WIDTH-1:0]  count,

    // Memory
    output logic                                 mem_req_valid,
    output logic                                 mem_req_rw,
    output logic [cluster_pkg::ADDR_WIDTH-1:0]   mem_req_addr,
    output logic [cluster_pkg::DATA_WIDTH-1:0]   mem_req_data,
    input  wire                                  mem_req_ready,
    input  wire                                  mem_rsp_valid,
    input  wire  [cluster_pkg::DATA_WIDTH-1:0]   mem_rsp_data,

    // Shared multiply-add unit
    output logic                                 mul_req_valid,
    output logic [cluster_pkg::DATA_WIDTH-1:0]   mul_req_data,
    input  wire                                  mul_req_ready,
    input  wire                                  mul_rsp_valid,
    input  wire  [cluster_pkg::DATA_WIDTH-1:0]   mul_rsp_data,

    output logic                                 busy
);
    import cluster_pkg::*;

    logic [STATE_WIDTH-1:0] state;
    logic [COUNT_WIDTH-1:0] idx;
    logic [DATA_WIDTH-1:0]  word;
    logic [ADDR_WIDTH-1:0]  slice_off;
    logic [ADDR_WIDTH-1:0]  elem_off;
    logic                   last_elem;

    // Each core owns count consecutive words in both arrays
    assign slice_off = ADDR_WIDTH'(CORE_ID) * ADDR_WIDTH'(count);
    assign elem_off  = slice_off + ADDR_WIDTH'(idx);
    assign last_elem = (idx == count - COUNT_WIDTH'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start && (count != '0)) begin
                        state <= ST_READ;
                        idx   <= '0;
                    end
                end
                ST_READ: begin
                    if (mem_req_ready)
                        state <= ST_WAIT_READ;
                end
                ST_WAIT_READ: begin
                    if (mem_rsp_valid)
                        state <= ST_MUL;
                end
                ST_MUL: begin
                    if (mul_req_ready)
                        state <= ST_WAIT_MUL;
                end
                ST_WAIT_MUL: begin
                    if (mul_rsp_valid)
                        state <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (mem_req_ready) begin
                        if (last_elem) begin
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_READ;
                            idx   <= idx + COUNT_WIDTH'(1);
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // One word register carries the operand, then the result
    always_ff @(posedge clk) begin
        if (state == ST_WAIT_READ && mem_rsp_valid)
            word <= mem_rsp_data;
        else if (state == ST_WAIT_MUL && mul_rsp_valid)
            word <= mul_rsp_data;
    end

    assign mem_req_valid = (state == ST_READ) || (state == ST_WRITE);
    assign mem_req_rw    = (state == ST_WRITE);
    assign mem_req_addr  = ((state == ST_WRITE) ? dst_base : src_base) + elem_off;
    assign mem_req_data  = word;

    assign mul_req_valid = (state == ST_MUL);
    assign mul_req_data  = word;

    assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

//--- dcr_base.sv
`timescale 1ns/100ps
`default_nettype none

module dcr_base (
    input  wire                                  clk,
    input  wire                                  reset,

    input  wire                                  dcr_wr_valid,
    input  wire  [dcr_pkg::DCR_ADDR_WIDTH-1:0]   dcr_wr_addr,
    input  wire  [dcr_pkg::DCR_DATA_WIDTH-1:0]   dcr_wr_data,

    output logic [cluster_pkg::ADDR_WIDTH-1:0]   src_base,
    output logic [cluster_pkg::ADDR_WIDTH-1:0]   dst_base,
    output logic [cluster_pkg::COUNT_WIDTH-1:0]  count,
    output logic [cluster_pkg::DATA_WIDTH-1:0]   scale,
    output logic [cluster_pkg::DATA_WIDTH-1:0]   bias
);
    import cluster_pkg::*;
    import dcr_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            src_base <= '0;
            dst_base <= '0;
            count    <= '0;
            scale    <= '0;
            bias     <= '0;
        end else if (dcr_wr_valid) begin
            // Unmapped addresses fall through untouched
            case (dcr_wr_addr)
                DCR_SRC_BASE: src_base <= dcr_wr_data[ADDR_WIDTH-1:0];
                DCR_DST_BASE: dst_base <= dcr_wr_data[ADDR_WIDTH-1:0];
                DCR_COUNT:    count    <= dcr_wr_data[COUNT_WIDTH-1:0];
                DCR_SCALE:    scale    <= dcr_wr_data[DATA_WIDTH-1:0];
                DCR_BIAS:     bias     <= dcr_wr_data[DATA_WIDTH-1:0];
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- dcr_pkg.sv
`default_nettype none

package dcr_pkg;

    localparam int DCR_ADDR_WIDTH = 12;
    localparam int DCR_DATA_WIDTH = 32;

    // Launch configuration register map
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_SRC_BASE = 12'h001;
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_DST_BASE = 12'h002;
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_COUNT    = 12'h003;
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_SCALE    = 12'h004;
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_BIAS     = 12'h005;

endpackage

`default_nettype wire

//--- mem_arb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arb (
    input  wire                                                       clk,
    input  wire                                                       reset,

    // Per-core request side
    input  wire  [cluster_pkg::NUM_CORES-1:0]                         core_mem_req_valid,
    input  wire  [cluster_pkg::NUM_CORES-1:0]                         core_mem_req_rw,
    input  wire  [cluster_pkg::NUM_CORES-1:0][cluster_pkg::ADDR_WIDTH-1:0] core_mem_req_addr,
    input  wire  [cluster_pkg::NUM_CORES-1:0][cluster_pkg::DATA_WIDTH-1:0] core_mem_req_data,
    output logic [cluster_pkg::NUM_CORES-1:0]                         core_mem_req_ready,
    output logic [cluster_pkg::NUM_CORES-1:0]                         core_mem_rsp_valid,
    output logic [cluster_pkg::DATA_WIDTH-1:0]                        core_mem_rsp_data,

    // External port
    output logic                                                      mem_req_valid,
    output logic                                                      mem_req_rw,
    output logic [cluster_pkg::ADDR_WIDTH-1:0]                        mem_req_addr,
    output logic [cluster_pkg::DATA_WIDTH-1:0]                        mem_req_data,
    output logic [cluster_pkg::CORE_ID_WIDTH-1:0]                     mem_req_tag,
    input  wire                                                       mem_req_ready,
    input  wire                                                       mem_rsp_valid,
    input  wire  [cluster_pkg::DATA_WIDTH-1:0]                        mem_rsp_data,
    input  wire  [cluster_pkg::CORE_ID_WIDTH-1:0]                     mem_rsp_tag
);
    import cluster_pkg::*;

    logic [CORE_ID_WIDTH-1:0] grant_index;
    logic                     grant_valid;

    rr_arbiter #(
        .NUM_REQS (NUM_CORES)
    ) req_arb (
        .clk         (clk),
        .reset       (reset),
        .requests    (core_mem_req_valid),
        .accept      (mem_req_ready),
        .grant_index (grant_index),
        .grant_valid (grant_valid)
    );

    assign mem_req_valid = grant_valid;
    assign mem_req_rw    = core_mem_req_rw[grant_index];
    assign mem_req_addr  = core_mem_req_addr[grant_index];
    assign mem_req_data  = core_mem_req_data[grant_index];
    assign mem_req_tag   = grant_index;

    // Ready back to the granted core, read data back by tag
    for (genvar i = 0; i < NUM_CORES; ++i) begin : g_route
        assign core_mem_req_ready[i] = mem_req_ready && grant_valid
                                     && (grant_index == CORE_ID_WIDTH'(i));
        assign core_mem_rsp_valid[i] = mem_rsp_valid && (mem_rsp_tag == CORE_ID_WIDTH'(i));
    end

    assign core_mem_rsp_data = mem_rsp_data;

endmodule

`default_nettype wire

//--- mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mul_unit (
    input  wire                                                       clk,
    input  wire                                                       reset,

    input  wire  [cluster_pkg::NUM_CORES-1:0]                         mul_req_valid,
    input  wire  [cluster_pkg::NUM_CORES-1:0][cluster_pkg::DATA_WIDTH-1:0] mul_req_data,
    output logic [cluster_pkg::NUM_CORES-1:0]                         mul_req_ready,

    input  wire  [cluster_pkg::DATA_WIDTH-1:0]                        scale,
    input  wire  [cluster_pkg::DATA_WIDTH-1:0]                        bias,

    output logic [cluster_pkg::NUM_CORES-1:0]                         mul_rsp_valid,
    output logic [cluster_pkg::DATA_WIDTH-1:0]                        mul_rsp_data
);
    import cluster_pkg::*;

    logic [CORE_ID_WIDTH-1:0] grant_index;
    logic                     grant_valid;

    logic                     s1_valid;
    logic [CORE_ID_WIDTH-1:0] s1_tag;
    logic [DATA_WIDTH-1:0]    s1_prod;
    logic                     s2_valid;
    logic [CORE_ID_WIDTH-1:0] s2_tag;
    logic [DATA_WIDTH-1:0]    s2_result;

    // Pipeline never stalls, so every grant is taken at once
    rr_arbiter #(
        .NUM_REQS (NUM_CORES)
    ) req_arb (
        .clk         (clk),
        .reset       (reset),
        .requests    (mul_req_valid),
        .accept      (grant_valid),
        .grant_index (grant_index),
        .grant_valid (grant_valid)
    );

    for (genvar i = 0; i < NUM_CORES; ++i) begin : g_ports
        assign mul_req_ready[i] = grant_valid && (grant_index == CORE_ID_WIDTH'(i));
        assign mul_rsp_valid[i] = s2_valid && (s2_tag == CORE_ID_WIDTH'(i));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= grant_valid;
            s2_valid <= s1_valid;
        end
    end

    // Low word of the product, then the bias
    always_ff @(posedge clk) begin
        s1_tag    <= grant_index;
        s1_prod   <= mul_req_data[grant_index] * scale;
        s2_tag    <= s1_tag;
        s2_result <= s1_prod + bias;
    end

    assign mul_rsp_data = s2_result;

endmodule

`default_nettype wire

//--- rr_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter #(
    parameter int NUM_REQS = 2
) (
    input  wire                                           clk,
    input  wire                                           reset,
    input  wire  [NUM_REQS-1:0]                           requests,
    input  wire                                           accept,
    output logic [((NUM_REQS > 1) ? $clog2(NUM_REQS) : 1)-1:0] grant_index,
    output logic                                          grant_valid
);
    localparam int IDX_W = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;

    logic [IDX_W-1:0] ptr;
    logic             hold;
    logic [IDX_W-1:0] hold_index;

    always_comb begin
        int cand;
        grant_valid = 1'b0;
        grant_index = ptr;
        cand = 0;
        if (hold) begin
            // A stalled grant stays put until it is taken
            grant_valid = requests[hold_index];
            grant_index = hold_index;
        end else begin
            for (int i = 0; i < NUM_REQS; i++) begin
                cand = (int'(ptr) + i) % NUM_REQS;
                if (!grant_valid && requests[cand]) begin
                    grant_valid = 1'b1;
                    grant_index = IDX_W'(cand);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr  <= '0;
            hold <= 1'b0;
        end else begin
            hold <= grant_valid && !accept;
            if (grant_valid && accept)
                ptr <= IDX_W'((int'(grant_index) + 1) % NUM_REQS);
        end
    end

    always_ff @(posedge clk) begin
        hold_index <= grant_index;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cluster -f vlog.f -o sim_cluster
./obj_dir/sim_cluster | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tb_cluster.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cluster;
    import cluster_pkg::*;
    import dcr_pkg::*;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  src_base;
        logic [ADDR_WIDTH-1:0]  dst_base;
        logic [COUNT_WIDTH-1:0] count;
        logic [DATA_WIDTH-1:0]  scale;
        logic [DATA_WIDTH-1:0]  bias;
        logic [7:0]             stall_pct;
        logic                   bad_dcr;
    } row_t;

    localparam int NUM_ROWS = 5;

    // src, dst, count, scale, bias, stall percent, extra unmapped DCR write
    row_t rows [NUM_ROWS] = '{
        '{16'h0100, 16'h0400, 8'd6,  32'h0000_0003, 32'h0000_0007, 8'd0,  1'b0},
        '{16'h0800, 16'h0c00, 8'd10, 32'h1234_5679, 32'hdead_beef, 8'd40, 1'b0},
        '{16'h1000, 16'h1400, 8'd5,  32'h0000_0005, 32'h0000_0001, 8'd25, 1'b1},
        '{16'h2000, 16'h2400, 8'd0,  32'h0000_0009, 32'h0000_0002, 8'd0,  1'b0},
        '{16'h3000, 16'h3400, 8'd12, 32'hffff_fffd, 32'h8000_0000, 8'd60, 1'b1}
    };

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      dcr_wr_valid;
    logic [DCR_ADDR_WIDTH-1:0] dcr_wr_addr;
    logic [DCR_DATA_WIDTH-1:0] dcr_wr_data;
    logic                      start;
    logic                      mem_req_valid;
    logic                      mem_req_rw;
    logic [ADDR_WIDTH-1:0]     mem_req_addr;
    logic [DATA_WIDTH-1:0]     mem_req_data;
    logic [CORE_ID_WIDTH-1:0]  mem_req_tag;
    logic                      mem_req_ready = 1'b0;
    logic                      mem_rsp_valid = 1'b0;
    logic [DATA_WIDTH-1:0]     mem_rsp_data = '0;
    logic [CORE_ID_WIDTH-1:0]  mem_rsp_tag = '0;
    logic                      busy;

    logic [DATA_WIDTH-1:0] mem    [0:(1 << ADDR_WIDTH)-1];
    logic [DATA_WIDTH-1:0] golden [0:(1 << ADDR_WIDTH)-1];

    // Pending read responses with the oldest in front
    logic [DATA_WIDTH-1:0]    rsp_data_q [$];
    logic [CORE_ID_WIDTH-1:0] rsp_tag_q  [$];
    int                       rsp_due_q  [$];

    logic [31:0] fill_state = 32'd17;
    logic [31:0] model_state = 32'd17;
    logic [7:0]  stall_pct = 8'd0;
    logic                     held_valid = 1'b0;
    logic                     held_rw;
    logic [ADDR_WIDTH-1:0]    held_addr;
    logic [DATA_WIDTH-1:0]    held_data;
    logic [CORE_ID_WIDTH-1:0] held_tag;
    logic [ADDR_WIDTH-1:0]    cur_src = '0;
    logic [ADDR_WIDTH-1:0]    cur_dst = '0;
    int cur_count = 0;
    int neg_cycle = 0;
    int cycle_count = 0;
    int timeout_limit = 200;
    int read_count = 0;
    int write_count = 0;
    int req_seen = 0;
    int error_count = 0;
    int test_count = 0;
    int fail_count = 0;

    cluster cluster_inst (
        .clk           (clk),
        .reset         (reset),
        .dcr_wr_valid  (dcr_wr_valid),
        .dcr_wr_addr   (dcr_wr_addr),
        .dcr_wr_data   (dcr_wr_data),
        .start         (start),
        .mem_req_valid (mem_req_valid),
        .mem_req_rw    (mem_req_rw),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .busy          (busy)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Low word of src * scale + bias
    function automatic logic [DATA_WIDTH-1:0] compute_expected(
        input logic [DATA_WIDTH-1:0] src,
        input logic [DATA_WIDTH-1:0] scale,
        input logic [DATA_WIDTH-1:0] bias
    );
        logic [63:0] prod;
        prod = 64'(src) * 64'(scale);
        return prod[31:0] + bias;
    endfunction

    // Core whose slice holds an address of the current launch
    function automatic int owner_core(input logic [ADDR_WIDTH-1:0] addr,
                                      input logic [ADDR_WIDTH-1:0] base,
                                      input int                    cnt);
        logic [ADDR_WIDTH-1:0] off;
        off = addr - base;
        if (cnt == 0)
            return -1;
        return int'(off) / cnt;
    endfunction

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: FAIL with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic write_dcr(input logic [DCR_ADDR_WIDTH-1:0] addr,
                             input logic [DCR_DATA_WIDTH-1:0] data);
        dcr_wr_valid = 1'b1;
        dcr_wr_addr  = addr;
        dcr_wr_data  = data;
        @(negedge clk);
        dcr_wr_valid = 1'b0;
    endtask

    // Memory model works on the falling edge where DUT outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            mem_req_ready = 1'b0;
            mem_rsp_valid = 1'b0;
            held_valid    = 1'b0;
        end else begin
            neg_cycle++;
            mem_rsp_valid = 1'b0;
            if (rsp_due_q.size() != 0 && rsp_due_q[0] <= neg_cycle) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = rsp_data_q.pop_front();
                mem_rsp_tag   = rsp_tag_q.pop_front();
                void'(rsp_due_q.pop_front());
            end
            // Stalled request must hold every field
            if (held_valid) begin
                check_value("mem_req_valid", 32'(mem_req_valid), 32'd1);
                check_value("mem_req_rw", 32'(mem_req_rw), 32'(held_rw));
                check_value("mem_req_addr", 32'(mem_req_addr), 32'(held_addr));
                check_value("mem_req_data", mem_req_data, held_data);
                check_value("mem_req_tag", 32'(mem_req_tag), 32'(held_tag));
            end
            model_state   = lcg_next(model_state);
            mem_req_ready = ((model_state >> 16) % 100) >= 32'(stall_pct);
            held_valid    = mem_req_valid && !mem_req_ready;
            held_rw       = mem_req_rw;
            held_addr     = mem_req_addr;
            held_data     = mem_req_data;
            held_tag      = mem_req_tag;
            if (mem_req_valid) begin
                req_seen++;
            end
            if (mem_req_valid && mem_req_ready) begin
                check_value("mem_req_tag", 32'(mem_req_tag),
                            32'(owner_core(mem_req_addr, mem_req_rw ? cur_dst : cur_src,
                                           cur_count)));
            end
            if (mem_req_valid && mem_req_ready && mem_req_rw) begin
                mem[mem_req_addr] = mem_req_data;
                write_count++;
            end else if (mem_req_valid && mem_req_ready) begin
                model_state = lcg_next(model_state);
                rsp_data_q.push_back(mem[mem_req_addr]);
                rsp_tag_q.push_back(mem_req_tag);
                rsp_due_q.push_back(neg_cycle + 1 + int'((model_state >> 16) % 4));
                read_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_idle();
        int errs;
        errs = error_count;
        repeat (20) begin
            check_value("busy", 32'(busy), 32'd0);
            check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
            @(negedge clk);
        end
        report_test("idle after reset", errs);
    endtask

    // Sources unchanged, results in place, earlier rows untouched
    task automatic verify_regions(input int last);
        logic [ADDR_WIDTH-1:0] a;
        for (int r = 0; r <= last; r++) begin
            for (int i = 0; i < NUM_CORES * int'(rows[r].count); i++) begin
                a = rows[r].src_base + ADDR_WIDTH'(i);
                check_value($sformatf("mem[%h]", a), mem[a], golden[a]);
                a = rows[r].dst_base + ADDR_WIDTH'(i);
                check_value($sformatf("mem[%h]", a), mem[a], golden[a]);
            end
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        int   n;
        int   errs;
        logic [ADDR_WIDTH-1:0] a;
        row  = rows[r];
        n    = NUM_CORES * int'(row.count);
        errs = error_count;
        for (int i = 0; i < n; i++) begin
            fill_state = lcg_next(fill_state);
            a = row.src_base + ADDR_WIDTH'(i);
            mem[a]    = fill_state;
            golden[a] = fill_state;
            golden[row.dst_base + ADDR_WIDTH'(i)] =
                compute_expected(fill_state, row.scale, row.bias);
        end
        stall_pct = row.stall_pct;
        cur_src   = row.src_base;
        cur_dst   = row.dst_base;
        cur_count = int'(row.count);
        write_dcr(DCR_SRC_BASE, 32'(row.src_base));
        if (row.bad_dcr)
            write_dcr(12'h006, 32'hffff_ffff);
        write_dcr(DCR_DST_BASE, 32'(row.dst_base));
        write_dcr(DCR_COUNT, 32'(row.count));
        write_dcr(DCR_SCALE, row.scale);
        write_dcr(DCR_BIAS, row.bias);
        if (row.bad_dcr)
            write_dcr(12'h000, 32'h0000_00ff);
        read_count  = 0;
        write_count = 0;
        req_seen    = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (n != 0) begin
            check_value("busy", 32'(busy), 32'd1);
            while (busy)
                @(negedge clk);
        end else begin
            repeat (20) begin
                check_value("busy", 32'(busy), 32'd0);
                @(negedge clk);
            end
            check_value("mem_req_valid count", 32'(req_seen), 32'd0);
        end
        check_value("read count", 32'(read_count), 32'(n));
        check_value("write count", 32'(write_count), 32'(n));
        verify_regions(r);
        report_test($sformatf("row %0d, count %0d, stall %0d%%", r, row.count,
                              row.stall_pct), errs);
    endtask

    initial begin
        reset        = 1'b1;
        dcr_wr_valid = 1'b0;
        dcr_wr_addr  = '0;
        dcr_wr_data  = '0;
        start        = 1'b0;
        for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
            mem[a]    = {~a[15:0], a[15:0]};
            golden[a] = {~a[15:0], a[15:0]};
        end
        for (int r = 0; r < NUM_ROWS; r++)
            timeout_limit += 40 * NUM_CORES * int'(rows[r].count);
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_idle();
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("Summary: %0d tests, %0d failed, %0d errors", test_count, fail_count,
                 error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
cluster_pkg.sv
dcr_pkg.sv
dcr_base.sv
rr_arbiter.sv
mem_arb.sv
mul_unit.sv
core.sv
cluster.sv
tb_cluster.sv
